//--- flist.f
hw/gfx_pkg.sv
hw/gfx_if.sv
hw/bg_fetch.sv
hw/line_buffer.sv
hw/pixel_compose.sv
hw/gfx_top.sv
testbench/gfx_properties.sv
testbench/tb_gfx_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gfx_top \
    -f flist.f -o sim_gfx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_gfx)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

//--- testbench/tb_gfx_top.sv
`timescale 1ns/1ps

module tb_gfx_top;
    import gfx_pkg::*;

    localparam int LINE_PERIOD = 260;

    logic               clock = 1'b0;
    logic               rst_n;
    logic               line_start;
    logic [7:0]         vcount;
    logic [15:0]        dispcnt;
    logic [15:0]        bg0cnt;
    logic [15:0]        bg1cnt;
    logic [15:0]        bg0hofs;
    logic [15:0]        bg1hofs;
    logic [15:0]        bg0vofs;
    logic [15:0]        bg1vofs;
    logic [15:0]        bldcnt;
    logic [15:0]        bldalpha;
    logic [COLOR_W-1:0] backdrop;
    logic [15:0]        vram_addr0;
    logic [15:0]        vram_addr1;
    logic [31:0]        vram_data0 = '0;
    logic [31:0]        vram_data1 = '0;
    logic [IDX_W-1:0]   pal_addr0;
    logic [IDX_W-1:0]   pal_addr1;
    logic [COLOR_W-1:0] pal_data0 = '0;
    logic [COLOR_W-1:0] pal_data1 = '0;
    logic [COLOR_W-1:0] output_color;
    logic               pixel_valid;

    logic [31:0]        vram0 [0:16383];
    logic [31:0]        vram1 [0:16383];
    int                 seed = 43;

    // Fetch settings of the line being fetched (cur) and of the line on screen (prev).
    logic               cur_ok = 1'b0;
    logic               prev_ok = 1'b0;
    int                 cur_vcount;
    int                 prev_vcount;
    logic               cur_en [2];
    logic               prev_en [2];
    logic               cur_bpp8 [2];
    logic               prev_bpp8 [2];
    int                 cur_hofs [2];
    int                 prev_hofs [2];
    int                 cur_vofs [2];
    int                 prev_vofs [2];

    int                 pix_x = 0;
    int                 checks = 0;
    int                 errors = 0;
    int                 base_checks = 0;
    int                 base_errors = 0;
    int                 n;
    logic [COLOR_W-1:0] want;

    always #10 clock = ~clock;

    gfx_top dut_i (
        .clock(clock), .rst_n(rst_n), .line_start(line_start), .vcount(vcount),
        .dispcnt(dispcnt), .bg0cnt(bg0cnt), .bg1cnt(bg1cnt),
        .bg0hofs(bg0hofs), .bg1hofs(bg1hofs), .bg0vofs(bg0vofs), .bg1vofs(bg1vofs),
        .bldcnt(bldcnt), .bldalpha(bldalpha), .backdrop(backdrop),
        .vram_addr0(vram_addr0), .vram_addr1(vram_addr1),
        .vram_data0(vram_data0), .vram_data1(vram_data1),
        .pal_addr0(pal_addr0), .pal_addr1(pal_addr1),
        .pal_data0(pal_data0), .pal_data1(pal_data1),
        .output_color(output_color), .pixel_valid(pixel_valid)
    );

    bind gfx_top gfx_properties #(.LINE_W(LINE_W)) props_i (
        .clock(clock), .rst_n(rst_n), .line_start(line_start), .pixel_valid(pixel_valid),
        .vram_addr0(vram_addr0), .vram_addr1(vram_addr1),
        .pal_addr0(pal_addr0), .pal_addr1(pal_addr1)
    );

    function automatic logic [COLOR_W-1:0] palette_color(input logic [7:0] i);
        logic [15:0] c;
        c = {8'h00, i} * 16'h0421;
        return c[14:0];
    endfunction

    // Both memories answer one cycle after the address.
    always @(posedge clock) begin
        vram_data0 <= vram0[vram_addr0[13:0]];
        vram_data1 <= vram1[vram_addr1[13:0]];
        pal_data0 <= palette_color(pal_addr0);
        pal_data1 <= palette_color(pal_addr1);
    end

    task automatic fill_vram();
        vram_word_u w;
        for (int a = 0; a < 16384; a++) begin
            w = $random(seed);
            if (a % 32 == 0) begin
                w.p4[0] = w.p4[0] | 4'h1;    // Leftmost pixel of each row is opaque.
            end
            vram0[a] = w;
            w = $random(seed);
            if (a % 32 == 0) begin
                w.p4[0] = w.p4[0] | 4'h1;
            end
            vram1[a] = w;
        end
    endtask

    function automatic logic [7:0] layer_index(input int l, input int x);
        vram_word_u  w;
        logic [13:0] a;
        int          px;
        int          row;
        if (!prev_ok || !prev_en[l]) begin
            return 8'h00;
        end
        px = (x + prev_hofs[l]) % 256;
        row = (prev_vcount + prev_vofs[l]) % 256;
        if (prev_bpp8[l]) begin
            a = 14'(row * 64 + px / 4);
        end else begin
            a = 14'(row * 32 + px / 8);
        end
        w = (l == 0) ? vram0[a] : vram1[a];
        if (prev_bpp8[l]) begin
            return w.p8[2'(px % 4)];
        end
        return {4'h0, w.p4[3'(px % 8)]};
    endfunction

    function automatic logic [COLOR_W-1:0] weighted_mix(input logic [14:0] f,
                                                         input logic [14:0] s,
                                                         input int ka, input int kb);
        logic [14:0] r;
        int          v;
        for (int c = 0; c < 3; c++) begin
            v = (int'(f[c*5 +: 5]) * ka + int'(s[c*5 +: 5]) * kb) >> BLD_SHIFT;
            r[c*5 +: 5] = (v > 31) ? 5'd31 : 5'(v);
        end
        return r;
    endfunction

    function automatic logic [COLOR_W-1:0] expected_color(input int x);
        logic [7:0]  i0;
        logic [7:0]  i1;
        logic [14:0] front;
        logic [14:0] second;
        logic        front_tgt;
        logic        second_tgt;
        int          eva;
        int          evb;
        i0 = layer_index(0, x);
        i1 = layer_index(1, x);
        front = backdrop;           // Nothing opaque leaves the backdrop in front.
        second = backdrop;
        front_tgt = 1'b0;
        second_tgt = 1'b0;
        if (i0 != 0 && i1 != 0 && bg1cnt[1:0] < bg0cnt[1:0]) begin
            front = palette_color(i1);
            front_tgt = bldcnt[1];
            second = palette_color(i0);
            second_tgt = bldcnt[8];
        end else if (i0 != 0) begin
            front = palette_color(i0);
            front_tgt = bldcnt[0];
            second = (i1 != 0) ? palette_color(i1) : backdrop;
            second_tgt = (i1 != 0) ? bldcnt[9] : bldcnt[13];
        end else if (i1 != 0) begin
            front = palette_color(i1);
            front_tgt = bldcnt[1];
            second_tgt = bldcnt[13];
        end
        eva = (bldalpha[4:0] > 5'd16) ? 16 : int'(bldalpha[4:0]);
        evb = (bldalpha[12:8] > 5'd16) ? 16 : int'(bldalpha[12:8]);
        if (bldcnt[7:6] == 2'b01 && front_tgt && second_tgt) begin
            return weighted_mix(front, second, eva, evb);
        end
        return front;
    endfunction

    // Every valid pixel is compared with the model of the line on screen.
    always @(posedge clock) begin
        if (pixel_valid) begin
            want = expected_color(pix_x);
            checks++;
            assert (output_color == want) else begin
                $display("mismatch output_color x=%0d got %h expected %h",
                         pix_x, output_color, want);
                errors++;
            end
            pix_x++;
        end else begin
            pix_x = 0;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic begin_line();
        @(negedge clock);
        prev_ok = cur_ok;
        prev_vcount = cur_vcount;
        for (int l = 0; l < 2; l++) begin
            prev_en[l] = cur_en[l];
            prev_bpp8[l] = cur_bpp8[l];
            prev_hofs[l] = cur_hofs[l];
            prev_vofs[l] = cur_vofs[l];
        end
        cur_ok = 1'b1;
        cur_vcount = int'(vcount);
        cur_en[0] = dispcnt[8];
        cur_en[1] = dispcnt[9];
        cur_bpp8[0] = bg0cnt[7];
        cur_bpp8[1] = bg1cnt[7];
        cur_hofs[0] = int'(bg0hofs[7:0]);
        cur_hofs[1] = int'(bg1hofs[7:0]);
        cur_vofs[0] = int'(bg0vofs[7:0]);
        cur_vofs[1] = int'(bg1vofs[7:0]);
        line_start = 1'b1;
        @(negedge clock);
        line_start = 1'b0;
        vcount = vcount + 8'd1;
    endtask

    task automatic wait_valid_rise(output int cycles);
        cycles = 1;
        while (!pixel_valid) begin
            if (cycles > 10) begin
                abort_run("timeout: pixel_valid never rose after line_start");
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic run_line();
        int cycles;
        begin_line();
        wait_valid_rise(cycles);
        while (pixel_valid) begin
            if (cycles > LINE_W + 10) begin
                abort_run("timeout: pixel_valid never fell at the end of the line");
            end
            @(negedge clock);
            cycles++;
        end
        while (cycles < LINE_PERIOD - 1) begin
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        int n_chk;
        int n_err;
        n_chk = checks - base_checks;
        n_err = errors - base_errors;
        $display("test %0d %s: %0d pixels, %0d errors", num, name, n_chk, n_err);
        base_checks = checks;
        base_errors = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        line_start = 1'b0;
        vcount = 8'd0;
        dispcnt = 16'h0300;
        bg0cnt = 16'h0001;
        bg1cnt = 16'h0002;
        bg0hofs = 16'h0000;
        bg1hofs = 16'h0000;
        bg0vofs = 16'h0000;
        bg1vofs = 16'h0000;
        bldcnt = 16'h0000;
        bldalpha = 16'h0000;
        backdrop = 15'h1234;
        fill_vram();
        repeat (4) @(negedge clock);
        rst_n = 1'b1;

        repeat (3) run_line();
        report_test(1, "4 bpp priority");

        bg0hofs = 16'h00C8;         // x + 200 wraps past 255.
        bg1hofs = 16'h0137;
        bg0vofs = 16'h00FA;
        bg1vofs = 16'h0105;
        repeat (3) run_line();
        report_test(2, "scroll wrap");

        bg0cnt = 16'h0002;
        bg1cnt = 16'h0080;          // 8 bpp at priority 0.
        bg0hofs = 16'h0011;
        repeat (3) run_line();
        report_test(3, "8 bpp front layer");

        bldcnt = 16'h2343;
        bldalpha = 16'h0808;
        repeat (2) run_line();
        bldalpha = 16'h1414;        // Both clamp to 16.
        repeat (2) run_line();
        report_test(4, "alpha blend");

        dispcnt = 16'h0200;
        bldcnt = 16'h2042;
        bldalpha = 16'h060A;
        repeat (3) run_line();
        report_test(5, "BG0 off, blend with backdrop");

        dispcnt = 16'h0300;
        bldcnt = 16'h0000;
        begin_line();
        wait_valid_rise(n);
        repeat (100) @(negedge clock);
        rst_n = 1'b0;
        cur_ok = 1'b0;
        prev_ok = 1'b0;
        @(negedge clock);
        assert (!pixel_valid) else begin
            $display("pixel_valid stayed high after reset was applied");
            errors++;
        end
        repeat (3) @(negedge clock);
        rst_n = 1'b1;
        repeat (3) run_line();      // The first line shows only the backdrop.
        report_test(6, "reset mid-line");

        $display("tests 6, pixels %0d, errors %0d, property failures %0d",
                 checks, errors, dut_i.props_i.fail_count);
        if (errors == 0 && dut_i.props_i.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/gfx_properties.sv
`timescale 1ns/1ps

module gfx_properties #(
    parameter int LINE_W = gfx_pkg::LINE_W
) (
    input logic        clock,
    input logic        rst_n,
    input logic        line_start,
    input logic        pixel_valid,
    input logic [15:0] vram_addr0,
    input logic [15:0] vram_addr1,
    input logic [7:0]  pal_addr0,
    input logic [7:0]  pal_addr1
);

    int         fail_count = 0;
    logic [8:0] run_len;     // High cycles of pixel_valid so far in this run.
    logic [8:0] idle_len;    // Cycles since the last line_start, saturating.

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            run_len <= '0;
            idle_len <= '1;
        end else begin
            run_len <= pixel_valid ? run_len + 9'd1 : 9'd0;
            if (line_start) begin
                idle_len <= '0;
            end else if (idle_len != '1) begin
                idle_len <= idle_len + 9'd1;
            end
        end
    end

    valid_after_start: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(pixel_valid) |-> $past(line_start, 4))
        else begin
            $error("pixel_valid rose without a line_start four cycles before");
            fail_count++;
        end

    valid_not_too_long: assert property (@(posedge clock) disable iff (!rst_n)
        pixel_valid |-> run_len < 9'(LINE_W))
        else begin
            $error("pixel_valid stayed high for more than one line");
            fail_count++;
        end

    valid_full_line: assert property (@(posedge clock) disable iff (!rst_n)
        $fell(pixel_valid) |-> run_len == 9'(LINE_W))
        else begin
            $error("pixel_valid run was shorter than one line");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clock)
        !rst_n |-> !pixel_valid && vram_addr0 == '0 && vram_addr1 == '0
                   && pal_addr0 == '0 && pal_addr1 == '0)
        else begin
            $error("outputs were not quiet during reset");
            fail_count++;
        end

    // Once the fetch has walked the line, the address holds until the next line.
    addr_stable: assert property (@(posedge clock) disable iff (!rst_n)
        (idle_len > 9'(LINE_W) && !line_start) |-> $stable(vram_addr0) && $stable(vram_addr1))
        else begin
            $error("VRAM address moved while the fetch was idle");
            fail_count++;
        end

endmodule

//--- hw/gfx_top.sv
`timescale 1ns/1ps

module gfx_top #(
    parameter int LINE_W = gfx_pkg::LINE_W
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        line_start,
    input  logic [7:0]                  vcount,
    input  logic [15:0]                 dispcnt,
    input  logic [15:0]                 bg0cnt,
    input  logic [15:0]                 bg1cnt,
    input  logic [15:0]                 bg0hofs,
    input  logic [15:0]                 bg1hofs,
    input  logic [15:0]                 bg0vofs,
    input  logic [15:0]                 bg1vofs,
    input  logic [15:0]                 bldcnt,
    input  logic [15:0]                 bldalpha,
    input  logic [gfx_pkg::COLOR_W-1:0] backdrop,
    output logic [15:0]                 vram_addr0,
    output logic [15:0]                 vram_addr1,
    input  logic [31:0]                 vram_data0,
    input  logic [31:0]                 vram_data1,
    output logic [gfx_pkg::IDX_W-1:0]   pal_addr0,
    output logic [gfx_pkg::IDX_W-1:0]   pal_addr1,
    input  logic [gfx_pkg::COLOR_W-1:0] pal_data0,
    input  logic [gfx_pkg::COLOR_W-1:0] pal_data1,
    output logic [gfx_pkg::COLOR_W-1:0] output_color,
    output logic                        pixel_valid
);

    line_wr_if wr_if ();
    line_rd_if rd_if ();

    // Fetch fills one line ahead of the line being composed.
    bg_fetch #(.LINE_W(LINE_W)) fetch_i (
        .clock, .rst_n, .line_start, .vcount,
        .dispcnt, .bg0cnt, .bg1cnt,
        .bg0hofs, .bg1hofs, .bg0vofs, .bg1vofs,
        .vram_data0, .vram_data1,
        .vram_addr0, .vram_addr1,
        .wr(wr_if)
    );

    line_buffer #(.LINE_W(LINE_W)) buffer_i (
        .clock, .rst_n, .line_start,
        .wr(wr_if),
        .rd(rd_if)
    );

    pixel_compose #(.LINE_W(LINE_W)) compose_i (
        .clock, .rst_n, .line_start,
        .bg0cnt, .bg1cnt, .bldcnt, .bldalpha,
        .backdrop, .pal_data0, .pal_data1,
        .pal_addr0, .pal_addr1,
        .output_color, .pixel_valid,
        .rd(rd_if)
    );

endmodule

//--- hw/pixel_compose.sv
`timescale 1ns/1ps

module pixel_compose #(
    parameter int LINE_W = gfx_pkg::LINE_W
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        line_start,
    input  logic [15:0]                 bg0cnt,
    input  logic [15:0]                 bg1cnt,
    input  logic [15:0]                 bldcnt,
    input  logic [15:0]                 bldalpha,
    input  logic [gfx_pkg::COLOR_W-1:0] backdrop,
    input  logic [gfx_pkg::COLOR_W-1:0] pal_data0,
    input  logic [gfx_pkg::COLOR_W-1:0] pal_data1,
    output logic [gfx_pkg::IDX_W-1:0]   pal_addr0,
    output logic [gfx_pkg::IDX_W-1:0]   pal_addr1,
    output logic [gfx_pkg::COLOR_W-1:0] output_color,
    output logic                        pixel_valid,
    line_rd_if.src                      rd
);
    import gfx_pkg::*;

    logic               ractive;
    logic [7:0]         rx;
    logic [1:0]         vld_q;
    logic [1:0]         opaque_q;

    logic [4:0]         eva;
    logic [4:0]         evb;
    logic               bg0_front;
    logic               front_tgt;
    logic               second_tgt;
    logic               do_blend;
    logic [COLOR_W-1:0] front;
    logic [COLOR_W-1:0] second;
    logic [COLOR_W-1:0] blended;

    function automatic logic [4:0] clamp_ev(input logic [4:0] ev);
        return (ev > EV_MAX) ? 5'(EV_MAX) : ev;
    endfunction

    // One channel of the weighted sum, saturated to the channel maximum.
    function automatic logic [4:0] blend_ch(input logic [4:0] a, input logic [4:0] b,
                                            input logic [4:0] ka, input logic [4:0] kb);
        logic [10:0] sum;
        logic [10:0] shifted;
        sum = a * ka + b * kb;
        shifted = sum >> BLD_SHIFT;
        return (shifted > CH_MAX) ? 5'(CH_MAX) : shifted[4:0];
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ractive <= 1'b0;
            rx <= '0;
            vld_q <= '0;
            pixel_valid <= 1'b0;
        end else begin
            if (line_start) begin
                ractive <= 1'b1;
                rx <= '0;
            end else if (ractive) begin
                if (rx == 8'(LINE_W - 1)) begin
                    ractive <= 1'b0;
                end else begin
                    rx <= rx + 8'd1;
                end
            end
            vld_q <= {vld_q[0], ractive};   // Line buffer, then palette latency.
            pixel_valid <= vld_q[1];
        end
    end

    assign rd.rd_en = ractive;
    assign rd.rd_x = rx;
    assign pal_addr0 = rd.rd_idx0;
    assign pal_addr1 = rd.rd_idx1;

    // Opacity follows the index into the palette cycle.
    always_ff @(posedge clock) begin
        opaque_q <= {rd.rd_idx1 != '0, rd.rd_idx0 != '0};
    end

    always_comb begin
        bg0_front = opaque_q[0] && (!opaque_q[1] || bg0cnt[1:0] <= bg1cnt[1:0]);
        if (bg0_front) begin
            front = pal_data0;
            front_tgt = bldcnt[0];
            second = opaque_q[1] ? pal_data1 : backdrop;
            second_tgt = opaque_q[1] ? bldcnt[9] : bldcnt[13];
        end else if (opaque_q[1]) begin
            front = pal_data1;
            front_tgt = bldcnt[1];
            second = opaque_q[0] ? pal_data0 : backdrop;
            second_tgt = opaque_q[0] ? bldcnt[8] : bldcnt[13];
        end else begin
            front = backdrop;
            front_tgt = 1'b0;   // The backdrop alone is never blended.
            second = backdrop;
            second_tgt = 1'b0;
        end
        do_blend = (bldcnt[7:6] == BLD_MODE_ALPHA) && front_tgt && second_tgt;
    end

    assign eva = clamp_ev(bldalpha[4:0]);
    assign evb = clamp_ev(bldalpha[12:8]);
    assign blended = {blend_ch(front[14:10], second[14:10], eva, evb),
                      blend_ch(front[9:5], second[9:5], eva, evb),
                      blend_ch(front[4:0], second[4:0], eva, evb)};

    always_ff @(posedge clock) begin
        output_color <= do_blend ? blended : front;
    end

endmodule

//--- hw/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
    parameter int LINE_W = gfx_pkg::LINE_W
) (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   line_start,
    line_wr_if.dst wr,
    line_rd_if.dst rd
);
    import gfx_pkg::*;

    logic [2*IDX_W-1:0] mem [2][LINE_W];
    logic               bank_sel;     // Bank that is being filled.
    logic [1:0]         bank_valid;
    logic [2*IDX_W-1:0] rd_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bank_sel <= 1'b0;
            bank_valid <= 2'b00;
        end else begin
            if (line_start) begin
                bank_sel <= ~bank_sel;
            end
            if (wr.wr_en) begin
                bank_valid[bank_sel] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr.wr_en && wr.wr_x < LINE_W) begin
            mem[bank_sel][wr.wr_x] <= {wr.wr_idx1, wr.wr_idx0};
        end
    end

    // Reads come from the bank filled during the previous line.
    // A bank with no writes since reset returns index 0 for both layers.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (rd.rd_en) begin
            if (bank_valid[~bank_sel] && rd.rd_x < LINE_W) begin
                rd_q <= mem[~bank_sel][rd.rd_x];
            end else begin
                rd_q <= '0;
            end
        end
    end

    assign rd.rd_idx0 = rd_q[IDX_W-1:0];
    assign rd.rd_idx1 = rd_q[2*IDX_W-1:IDX_W];

endmodule

//--- hw/bg_fetch.sv
`timescale 1ns/1ps

module bg_fetch #(
    parameter int LINE_W = gfx_pkg::LINE_W
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                line_start,
    input  logic [7:0]          vcount,
    input  logic [15:0]         dispcnt,
    input  logic [15:0]         bg0cnt,
    input  logic [15:0]         bg1cnt,
    input  logic [15:0]         bg0hofs,
    input  logic [15:0]         bg1hofs,
    input  logic [15:0]         bg0vofs,
    input  logic [15:0]         bg1vofs,
    input  gfx_pkg::vram_word_u vram_data0,
    input  gfx_pkg::vram_word_u vram_data1,
    output logic [15:0]         vram_addr0,
    output logic [15:0]         vram_addr1,
    line_wr_if.src              wr
);
    import gfx_pkg::*;

    logic [15:0]      cnt_in [2];
    logic [15:0]      hofs_in [2];
    logic [15:0]      vofs_in [2];
    vram_word_u       data_in [2];

    logic             active;
    logic [7:0]       col;
    logic [7:0]       row_q [2];
    logic [7:0]       hofs_q [2];
    logic [1:0]       bpp8_q;
    logic [1:0]       en_q;

    logic [7:0]       px [2];
    logic [15:0]      addr [2];

    logic             d_valid;
    logic [7:0]       d_x;
    logic [2:0]       d_sub [2];
    logic [IDX_W-1:0] idx [2];

    // Layer 0 is BG0 on VRAM port 0, layer 1 is BG1 on port 1.
    assign cnt_in[0] = bg0cnt;
    assign cnt_in[1] = bg1cnt;
    assign hofs_in[0] = bg0hofs;
    assign hofs_in[1] = bg1hofs;
    assign vofs_in[0] = bg0vofs;
    assign vofs_in[1] = bg1vofs;
    assign data_in[0] = vram_data0;
    assign data_in[1] = vram_data1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            col <= '0;
            bpp8_q <= '0;
            en_q <= '0;
            for (int l = 0; l < 2; l++) begin
                row_q[l] <= '0;
                hofs_q[l] <= '0;
            end
        end else if (line_start) begin
            active <= 1'b1;
            col <= '0;
            for (int l = 0; l < 2; l++) begin
                row_q[l] <= vcount + vofs_in[l][7:0];   // Wraps at 256.
                hofs_q[l] <= hofs_in[l][7:0];
                bpp8_q[l] <= cnt_in[l][7];
                en_q[l] <= dispcnt[8 + l];
            end
        end else if (active) begin
            if (col == 8'(LINE_W - 1)) begin
                active <= 1'b0;
            end else begin
                col <= col + 8'd1;
            end
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            px[l] = col + hofs_q[l];
            if (bpp8_q[l]) begin
                addr[l] = {2'b00, row_q[l], px[l][7:2]};    // 64 words per row.
            end else begin
                addr[l] = {3'b000, row_q[l], px[l][7:3]};   // 32 words per row.
            end
        end
    end

    assign vram_addr0 = addr[0];
    assign vram_addr1 = addr[1];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= active;
        end
    end

    // The column travels with the request so the word can be split on return.
    always_ff @(posedge clock) begin
        d_x <= col;
        for (int l = 0; l < 2; l++) begin
            d_sub[l] <= px[l][2:0];
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            if (!en_q[l]) begin
                idx[l] = '0;
            end else if (bpp8_q[l]) begin
                idx[l] = data_in[l].p8[d_sub[l][1:0]];
            end else begin
                idx[l] = IDX_W'(data_in[l].p4[d_sub[l]]);
            end
        end
    end

    assign wr.wr_en = d_valid;
    assign wr.wr_x = d_x;
    assign wr.wr_idx0 = idx[0];
    assign wr.wr_idx1 = idx[1];

endmodule

//--- hw/gfx_if.sv
`timescale 1ns/1ps

// Index pairs from the background fetch into the line store.
interface line_wr_if;
    import gfx_pkg::*;

    logic             wr_en;
    logic [7:0]       wr_x;
    logic [IDX_W-1:0] wr_idx0;    // BG0 palette index.
    logic [IDX_W-1:0] wr_idx1;    // BG1 palette index.

    modport src (
        output wr_en,
        output wr_x,
        output wr_idx0,
        output wr_idx1
    );

    modport dst (
        input  wr_en,
        input  wr_x,
        input  wr_idx0,
        input  wr_idx1
    );
endinterface

// Reads of the previous line, answered one cycle after rd_en.
interface line_rd_if;
    import gfx_pkg::*;

    logic             rd_en;
    logic [7:0]       rd_x;
    logic [IDX_W-1:0] rd_idx0;
    logic [IDX_W-1:0] rd_idx1;

    modport src (
        output rd_en,
        output rd_x,
        input  rd_idx0,
        input  rd_idx1
    );

    modport dst (
        input  rd_en,
        input  rd_x,
        output rd_idx0,
        output rd_idx1
    );
endinterface

//--- hw/gfx_pkg.sv
package gfx_pkg;

    localparam int LINE_W = 240;     // Visible pixels per line.
    localparam int IDX_W = 8;
    localparam int COLOR_W = 15;     // Three 5-bit channels.

    // Alpha coefficients are in sixteenths.
    localparam int BLD_SHIFT = 4;
    localparam int EV_MAX = 16;
    localparam int CH_MAX = 31;      // Largest value of one color channel.

    // BLDCNT bits 7:6 select the special effect.
    localparam logic [1:0] BLD_MODE_ALPHA = 2'b01;

    // One 32-bit VRAM word holds eight 4 bpp or four 8 bpp pixel indices.
    // Element 0 of either view is the leftmost pixel on screen.
    typedef union packed {
        logic [7:0][3:0] p4;
        logic [3:0][7:0] p8;
    } vram_word_u;

endpackage
